/* sim.f */
+incdir+include
verilog/tile_pkg.sv
verilog/tile_config_ctrl.sv
verilog/switch_box.sv
verilog/connect_box.sv
verilog/clb.sv
verilog/pe_tile_top.sv
test/tile_checker.sv
test/tb_pe_tile.sv

/* run_sim.sh */
#!/bin/sh
# build and run the tile testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sim.f --top-module tb_pe_tile -o tb_pe_tile

./obj_dir/tb_pe_tile | tee sim.log

# a missing pass line fails the script
grep -q "All tests passed!" sim.log

/* test/tb_pe_tile.sv */
`timescale 1ns/1ps

module tb_pe_tile;
	import tile_pkg::*;

	typedef enum logic [1:0] {
		K_WRITE,
		K_READ,
		K_TRACKS,
		K_STALL
	} kind_e;

	typedef struct packed {
		logic [3:0]  test;
		kind_e       kind;
		logic        rnd;       // data or tracks from xorshift
		logic [31:0] addr;
		logic [31:0] data;      // write data, track value or expected rdata
		logic [1:0]  resp;
		logic        chk_data;
	} step_t;

	localparam logic [15:0] ME = 16'h0003;
	localparam logic [15:0] OTHER = 16'h0011;
	localparam logic [1:0] RESP_OK = 2'b00;
	localparam logic [1:0] RESP_ERR = 2'b10;

	logic clk = 1'b0;
	logic arst_n;
	logic done;
	axil_req_t req;
	axil_rsp_t rsp;
	side_tracks_t track_in;
	side_tracks_t track_out;
	step_t steps[$];
	step_t cur;
	logic [31:0] rng;
	int err_count;
	int chk_count;

	always #10 clk = ~clk;

	pe_tile_top dut0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.tile_id   (ME),
		.axil_req  (req),
		.axil_rsp  (rsp),
		.track_in  (track_in),
		.track_out (track_out)
	);

	tile_checker chk0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.tile_id   (ME),
		.req       (req),
		.rsp       (rsp),
		.track_in  (track_in),
		.track_out (track_out),
		.test      (cur.test),
		.done      (done),
		.exp_resp  (cur.resp),
		.exp_data  (cur.data),
		.chk_data  (cur.chk_data),
		.err_count (err_count),
		.chk_count (chk_count)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic void add(input int test, input kind_e kind, input int rnd,
			input int target, input logic [15:0] id, input logic [31:0] data,
			input logic [1:0] resp, input int chk);
		step_t s;
		s = '{4'(test), kind, 1'(rnd), {16'(target), id}, data, resp, 1'(chk)};
		steps.push_back(s);
	endfunction

	function automatic logic ready_bit(input int which);
		case (which)
			0: return rsp.awready;
			1: return rsp.bvalid;
			2: return rsp.arready;
			default: return rsp.rvalid;
		endcase
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	// returns just after the handshake edge
	task automatic wait_for(input int which);
		int n;
		n = 0;
		#1;
		while (!ready_bit(which) && n < 16) begin
			@(posedge clk);
			#3;
			n++;
		end
		next_cycle();
	endtask

	task automatic write_cfg(input logic [31:0] addr, input logic [31:0] data, input int hold);
		req.awvalid = 1'b1;
		req.awaddr = addr;
		req.wvalid = 1'b1;
		req.wdata = data;
		req.bready = hold == 0;
		wait_for(0);
		req.awvalid = 1'b0;
		req.wvalid = 1'b0;
		if (hold > 0) begin
			req.awvalid = 1'b1;  // second write has to wait for the response
			req.wvalid = 1'b1;
			req.wdata = ~data;
			repeat (hold) next_cycle();
			req.awvalid = 1'b0;
			req.wvalid = 1'b0;
			req.bready = 1'b1;
		end
		wait_for(1);
		req.bready = 1'b0;
	endtask

	task automatic read_cfg(input logic [31:0] addr);
		req.arvalid = 1'b1;
		req.araddr = addr;
		req.rready = 1'b1;
		wait_for(2);
		req.arvalid = 1'b0;
		wait_for(3);
		req.rready = 1'b0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// stimulus table
	// ~~~~~~~~~~~~~~~~~~~~

	initial begin
		req = '0;
		track_in = '0;
		arst_n = 1'b0;
		done = 1'b0;
		cur = '0;
		rng = 32'h4fcd;
		// test, kind, random, target, tile id, data, resp, check rdata
		add(1, K_TRACKS, 0, 0, ME, 32'h0000_eeee, RESP_OK, 0);  // track 0 low on every side
		for (int t = 7; t >= 4; t--) begin
			add(1, K_READ, 0, t, ME, 0, RESP_OK, 1);
		end
		add(2, K_WRITE, 0, 7, ME, 32'hdead_beef, RESP_OK, 0);
		add(2, K_READ, 0, 7, ME, 32'hdead_beef, RESP_OK, 1);
		add(2, K_WRITE, 0, 6, ME, 32'hffff_fffd, RESP_OK, 0);
		add(2, K_READ, 0, 6, ME, 32'h5, RESP_OK, 1);
		add(2, K_WRITE, 0, 5, ME, 32'h0000_00aa, RESP_OK, 0);
		add(2, K_READ, 0, 5, ME, 32'h2, RESP_OK, 1);
		add(2, K_WRITE, 0, 4, ME, 32'h8000_0007, RESP_OK, 0);
		add(2, K_READ, 0, 4, ME, 32'h3, RESP_OK, 1);
		add(3, K_WRITE, 0, 7, OTHER, 32'h1234_5678, RESP_OK, 0);
		add(3, K_READ, 0, 7, ME, 32'hdead_beef, RESP_OK, 1);
		add(3, K_READ, 0, 7, OTHER, 0, RESP_OK, 1);
		add(3, K_WRITE, 0, 3, ME, 32'h1, RESP_ERR, 0);
		add(3, K_READ, 0, 8, ME, 0, RESP_ERR, 0);
		for (int r = 0; r < 2; r++) begin
			add(4, K_WRITE, 1, 7, ME, 0, RESP_OK, 0);  // random routing
			for (int k = 0; k < 3; k++) begin
				add(4, K_TRACKS, 1, 0, ME, 0, RESP_OK, 0);
			end
		end
		add(5, K_WRITE, 0, 7, ME, 0, RESP_OK, 0);
		add(5, K_WRITE, 0, 6, ME, 32'h1, RESP_OK, 0);  // north in track 1
		add(5, K_WRITE, 0, 5, ME, 32'h2, RESP_OK, 0);  // east in track 2
		for (int op = 0; op < 4; op++) begin
			add(5, K_WRITE, 0, 4, ME, op, RESP_OK, 0);
			for (int ab = 0; ab < 4; ab++) begin
				// a on north track 1 (bit 13) and b on east track 2 (bit 10)
				add(5, K_TRACKS, 0, 0, ME,
					32'h5a5a | ((ab >> 1) << 13) | ((ab & 1) << 10), RESP_OK, 0);
			end
		end
		add(5, K_WRITE, 0, 6, ME, 32'h5, RESP_OK, 0);  // north out track 1 feeds the pe back
		add(5, K_WRITE, 0, 4, ME, 32'h2, RESP_OK, 0);
		add(5, K_TRACKS, 1, 0, ME, 0, RESP_OK, 0);
		add(6, K_STALL, 0, 4, ME, 32'h1, RESP_OK, 0);
		add(6, K_READ, 0, 4, ME, 32'h1, RESP_OK, 1);

		repeat (8) @(posedge clk);
		#2 arst_n = 1'b1;
		foreach (steps[i]) begin
			cur = steps[i];
			if (cur.rnd) begin
				rng = xorshift(rng);
				cur.data = rng;
			end
			case (cur.kind)
				K_WRITE: write_cfg(cur.addr, cur.data, 0);
				K_STALL: write_cfg(cur.addr, cur.data, 6);
				K_READ:  read_cfg(cur.addr);
				default: begin
					track_in = side_tracks_t'(cur.data[15:0]);
					repeat (3) next_cycle();
				end
			endcase
		end
		done = 1'b1;
		repeat (2) next_cycle();
		$display("summary: %0d tests, %0d checks, %0d errors",
			steps[steps.size() - 1].test, chk_count, err_count);
		if (err_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// each row needs well under 40 cycles
	initial begin
		@(posedge arst_n);
		#(steps.size() * 40 * 20);
		$display("watchdog expired before all %0d steps completed", steps.size());
		$display("Test failures found");
		$finish;
	end

endmodule

/* test/tile_checker.sv */
`timescale 1ns/1ps

module tile_checker (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic [15:0]            tile_id,
	input  tile_pkg::axil_req_t    req,
	input  tile_pkg::axil_rsp_t    rsp,
	input  tile_pkg::side_tracks_t track_in,
	input  tile_pkg::side_tracks_t track_out,
	input  logic [3:0]             test,
	input  logic                   done,
	input  logic [1:0]             exp_resp,
	input  logic [31:0]            exp_data,
	input  logic                   chk_data,
	output int                     err_count,
	output int                     chk_count
);
	import tile_pkg::*;

	// mirrored configuration and pe register
	logic [31:0] sb;
	logic [2:0] cb0;
	logic [2:0] cb1;
	logic [1:0] op;
	logic pe;
	logic b_pend;
	logic r_pend;
	logic accept;
	logic a;
	logic b;
	logic [3:0] last_test;
	int test_errs;
	int aw_wait;
	int ar_wait;
	side_tracks_t exp_out;

	// sides numbered north 0 to west 3 with north in the top bits
	function automatic logic pick(input side_tracks_t v, input int s, input int t);
		logic [15:0] flat;
		flat = v;
		return flat[(3 - s) * 4 + t];
	endfunction

	function automatic side_tracks_t route(input logic [31:0] cfg, input side_tracks_t tin,
			input logic pe_v);
		logic [15:0] o;
		int f;
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < 4; t++) begin
				f = int'(cfg[2 * (4 * s + t) +: 2]);
				o[(3 - s) * 4 + t] = (f == 0) ? pe_v : pick(tin, (s + f) % 4, t);
			end
		end
		return o;
	endfunction

	function automatic logic operand(input logic [2:0] sel, input int s, input side_tracks_t tin,
			input side_tracks_t tout);
		return sel[2] ? pick(tout, s, int'(sel[1:0])) : pick(tin, s, int'(sel[1:0]));
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
		chk_count++;
		if (got !== want) begin
			err_count++;
			test_errs++;
			$display("ERROR %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic report_stuck(input string msg);
		err_count++;
		test_errs++;
		$display("%s", msg);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// sample between edges
	// ~~~~~~~~~~~~~~~~~~~~

	always @(negedge clk) begin
		if (!arst_n) begin
			sb = '0;
			cb0 = '0;
			cb1 = '0;
			op = '0;
			pe = 1'b0;
			b_pend = 1'b0;
			r_pend = 1'b0;
			aw_wait = 0;
			ar_wait = 0;
			last_test = '0;
			test_errs = 0;
			err_count = 0;
			chk_count = 0;
		end else begin
			if (test != last_test && !done) begin
				if (last_test != 0)
					$display("test %0d finished: %0d errors", last_test, test_errs);
				last_test = test;
				test_errs = 0;
			end else if (done && last_test != 0) begin
				$display("test %0d finished: %0d errors", last_test, test_errs);
				last_test = '0;
			end
			exp_out = route(sb, track_in, pe);
			compare("track_out", {16'h0, track_out}, {16'h0, exp_out});
			compare("bvalid", 32'(rsp.bvalid), 32'(b_pend));
			compare("rvalid", 32'(rsp.rvalid), 32'(r_pend));
			compare("awready", 32'(rsp.awready), 32'(req.awvalid && req.wvalid && !b_pend));
			compare("wready", 32'(rsp.wready), 32'(req.awvalid && req.wvalid && !b_pend));
			compare("arready", 32'(rsp.arready), 32'(!r_pend));
			if (rsp.bvalid && req.bready)
				compare("bresp", 32'(rsp.bresp), 32'(exp_resp));
			if (rsp.rvalid && req.rready) begin
				compare("rresp", 32'(rsp.rresp), 32'(exp_resp));
				if (chk_data)
					compare("rdata", rsp.rdata, exp_data);
			end
			aw_wait = (req.awvalid && !rsp.awready) ? aw_wait + 1 : 0;
			ar_wait = (req.arvalid && !rsp.arready) ? ar_wait + 1 : 0;
			if (aw_wait == 12)
				report_stuck("write request was still not accepted after 12 cycles");
			if (ar_wait == 12)
				report_stuck("read request was still not accepted after 12 cycles");

			// state after the coming edge where pe still sees the old opcode
			a = operand(cb0, 0, track_in, exp_out);
			b = operand(cb1, 1, track_in, exp_out);
			case (op)
				2'd0: pe = a & b;
				2'd1: pe = a | b;
				2'd2: pe = a ^ b;
				default: pe = ~(a & b);
			endcase
			accept = req.awvalid && req.wvalid && rsp.awready && rsp.wready;
			if (accept && req.awaddr[15:0] == tile_id) begin
				case (cfg_target_e'(req.awaddr[31:16]))
					CFG_SB:  sb = req.wdata;
					CFG_CB0: cb0 = req.wdata[2:0];
					CFG_CB1: cb1 = req.wdata[2:0];
					CFG_CLB: op = req.wdata[1:0];
					default: ;
				endcase
			end
			b_pend = b_pend ? !req.bready : accept;
			r_pend = r_pend ? !req.rready : (req.arvalid && rsp.arready);
		end
	end

endmodule

/* verilog/pe_tile_top.sv */
`timescale 1ns/1ps
`include "tile_cfg.svh"

module pe_tile_top (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic [`TILE_ID_W-1:0]  tile_id,
	input  tile_pkg::axil_req_t    axil_req,
	output tile_pkg::axil_rsp_t    axil_rsp,
	input  tile_pkg::side_tracks_t track_in,
	output tile_pkg::side_tracks_t track_out
);
	import tile_pkg::*;

	cfg_write_t cfg_wr;
	cfg_readback_t cfg_rb;

	logic op_a;  // from north connect box
	logic op_b;  // from east connect box
	logic pe_out;

	// ~~~~~~~~~~~~~~~~~~~~
	// configuration
	// ~~~~~~~~~~~~~~~~~~~~

	tile_config_ctrl ctrl0 (
		.clk      (clk),
		.arst_n   (arst_n),
		.tile_id  (tile_id),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.cfg_wr   (cfg_wr),
		.cfg_rb   (cfg_rb)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// datapath
	// ~~~~~~~~~~~~~~~~~~~~

	switch_box sb0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.cfg_wr    (cfg_wr),
		.track_in  (track_in),
		.pe_out    (pe_out),
		.track_out (track_out),
		.cfg_q     (cfg_rb.sb)
	);

	connect_box cb0 (
		.clk      (clk),
		.arst_n   (arst_n),
		.cfg_en   (cfg_wr.cb0_en),
		.cfg_data (cfg_wr.data[`CB_SEL_W-1:0]),
		.side_in  (track_in.north),
		.side_out (track_out.north),
		.operand  (op_a),
		.cfg_q    (cfg_rb.cb0)
	);

	connect_box cb1 (
		.clk      (clk),
		.arst_n   (arst_n),
		.cfg_en   (cfg_wr.cb1_en),
		.cfg_data (cfg_wr.data[`CB_SEL_W-1:0]),
		.side_in  (track_in.east),
		.side_out (track_out.east),
		.operand  (op_b),
		.cfg_q    (cfg_rb.cb1)
	);

	clb clb0 (
		.clk      (clk),
		.arst_n   (arst_n),
		.cfg_en   (cfg_wr.clb_en),
		.cfg_data (clb_op_e'(cfg_wr.data[$bits(clb_op_e)-1:0])),
		.op_a     (op_a),
		.op_b     (op_b),
		.pe_out   (pe_out),
		.op_q     (cfg_rb.clb)
	);

endmodule

/* verilog/clb.sv */
`timescale 1ns/1ps
`include "tile_cfg.svh"

module clb (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              cfg_en,
	input  tile_pkg::clb_op_e cfg_data,
	input  logic              op_a,
	input  logic              op_b,
	output logic              pe_out,
	output tile_pkg::clb_op_e op_q
);
	import tile_pkg::*;

	logic result;

	always_comb begin
		case (op_q)
			CLB_AND: result = op_a & op_b;
			CLB_OR:  result = op_a | op_b;
			CLB_XOR: result = op_a ^ op_b;
			default: result = ~(op_a & op_b);  // nand
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_q <= CLB_AND;
		end else if (cfg_en) begin
			op_q <= cfg_data;
		end
	end

	// registered so the switch box never closes a loop through the pe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pe_out <= 1'b0;
		end else begin
			pe_out <= result;
		end
	end

endmodule

/* verilog/connect_box.sv */
`timescale 1ns/1ps
`include "tile_cfg.svh"

module connect_box (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   cfg_en,
	input  logic [`CB_SEL_W-1:0]   cfg_data,
	input  logic [`TILE_TRACKS-1:0] side_in,
	input  logic [`TILE_TRACKS-1:0] side_out,
	output logic                   operand,
	output logic [`CB_SEL_W-1:0]   cfg_q
);

	logic [2*`TILE_TRACKS-1:0] tracks;

	// selects 0-3 take incoming tracks, 4-7 the outgoing ones
	assign tracks = {side_out, side_in};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg_q <= '0;  // incoming track 0
		end else if (cfg_en) begin
			cfg_q <= cfg_data;
		end
	end

	assign operand = tracks[cfg_q];

endmodule

/* verilog/switch_box.sv */
`timescale 1ns/1ps
`include "tile_cfg.svh"

module switch_box (
	input  logic                   clk,
	input  logic                   arst_n,
	input  tile_pkg::cfg_write_t   cfg_wr,
	input  tile_pkg::side_tracks_t track_in,
	input  logic                   pe_out,
	output tile_pkg::side_tracks_t track_out,
	output logic [`SB_SEL_W-1:0]   cfg_q
);
	import tile_pkg::*;

	// indexed north 0, east 1, south 2, west 3
	logic [`TILE_SIDES-1:0][`TILE_TRACKS-1:0] in_side;
	logic [`TILE_SIDES-1:0][`TILE_TRACKS-1:0] out_side;

	function automatic logic route(
		input sb_sel_e sel,
		input logic    pe,
		input logic    nxt,
		input logic    opp,
		input logic    prv
	);
		case (sel)
			SB_PE:   return pe;
			SB_NEXT: return nxt;
			SB_OPP:  return opp;
			default: return prv;  // SB_PREV
		endcase
	endfunction

	// reset value routes every output from the pe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg_q <= '0;
		end else if (cfg_wr.sb_en) begin
			cfg_q <= cfg_wr.data;
		end
	end

	assign in_side[0] = track_in.north;
	assign in_side[1] = track_in.east;
	assign in_side[2] = track_in.south;
	assign in_side[3] = track_in.west;

	// ~~~~~~~~~~~~~~~~~~~~
	// routing
	// ~~~~~~~~~~~~~~~~~~~~

	for (genvar s = 0; s < `TILE_SIDES; s++) begin : g_side
		for (genvar t = 0; t < `TILE_TRACKS; t++) begin : g_track
			sb_sel_e sel;

			assign sel = sb_sel_e'(cfg_q[2*(s*`TILE_TRACKS+t) +: 2]);

			// same track number on the chosen side
			assign out_side[s][t] = route(
				sel,
				pe_out,
				in_side[(s+1) % `TILE_SIDES][t],
				in_side[(s+2) % `TILE_SIDES][t],
				in_side[(s+3) % `TILE_SIDES][t]
			);
		end
	end

	assign track_out.north = out_side[0];
	assign track_out.east = out_side[1];
	assign track_out.south = out_side[2];
	assign track_out.west = out_side[3];

endmodule

/* verilog/tile_config_ctrl.sv */
`timescale 1ns/1ps
`include "tile_cfg.svh"

module tile_config_ctrl (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic [`TILE_ID_W-1:0]   tile_id,
	input  tile_pkg::axil_req_t     axil_req,
	output tile_pkg::axil_rsp_t     axil_rsp,
	output tile_pkg::cfg_write_t    cfg_wr,
	input  tile_pkg::cfg_readback_t cfg_rb
);
	import tile_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_RESP
	} ch_state_e;

	ch_state_e wr_state;
	ch_state_e rd_state;

	cfg_target_e aw_target;
	cfg_target_e ar_target;
	logic aw_mine;
	logic ar_mine;
	logic wr_accept;
	logic rd_accept;

	logic [1:0] bresp_q;
	logic [1:0] rresp_q;
	logic [`CFG_DATA_W-1:0] rdata_q;
	logic [`CFG_DATA_W-1:0] rd_mux;

	// unknown targets get SLVERR whatever the tile id
	function automatic logic [1:0] target_resp(input cfg_target_e t);
		case (t)
			CFG_SB, CFG_CB0, CFG_CB1, CFG_CLB: return AXI_OKAY;
			default: return AXI_SLVERR;
		endcase
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// address decode
	// ~~~~~~~~~~~~~~~~~~~~

	assign aw_target = cfg_target_e'(axil_req.awaddr[`CFG_ADDR_W-1:`TILE_ID_W]);
	assign ar_target = cfg_target_e'(axil_req.araddr[`CFG_ADDR_W-1:`TILE_ID_W]);
	assign aw_mine = axil_req.awaddr[`TILE_ID_W-1:0] == tile_id;
	assign ar_mine = axil_req.araddr[`TILE_ID_W-1:0] == tile_id;

	// address and data are taken in the same cycle
	assign wr_accept = (wr_state == ST_IDLE) && axil_req.awvalid && axil_req.wvalid;
	assign rd_accept = (rd_state == ST_IDLE) && axil_req.arvalid;

	always_comb begin
		axil_rsp.awready = wr_accept;
		axil_rsp.wready = wr_accept;
		axil_rsp.bvalid = wr_state == ST_RESP;
		axil_rsp.bresp = bresp_q;
		axil_rsp.arready = rd_state == ST_IDLE;
		axil_rsp.rvalid = rd_state == ST_RESP;
		axil_rsp.rdata = rdata_q;
		axil_rsp.rresp = rresp_q;
	end

	// one enable for one cycle, writes to other tiles fall through
	always_comb begin
		cfg_wr = '0;
		cfg_wr.data = axil_req.wdata;
		if (wr_accept && aw_mine) begin
			case (aw_target)
				CFG_SB:  cfg_wr.sb_en = 1'b1;
				CFG_CB0: cfg_wr.cb0_en = 1'b1;
				CFG_CB1: cfg_wr.cb1_en = 1'b1;
				CFG_CLB: cfg_wr.clb_en = 1'b1;
				default: ;
			endcase
		end
	end

	always_comb begin
		rd_mux = '0;  // other tile or bad target
		if (ar_mine) begin
			case (ar_target)
				CFG_SB:  rd_mux = cfg_rb.sb;
				CFG_CB0: rd_mux[`CB_SEL_W-1:0] = cfg_rb.cb0;
				CFG_CB1: rd_mux[`CB_SEL_W-1:0] = cfg_rb.cb1;
				CFG_CLB: rd_mux[$bits(clb_op_e)-1:0] = cfg_rb.clb;
				default: ;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// response channels
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_state <= ST_IDLE;
			rd_state <= ST_IDLE;
		end else begin
			case (wr_state)
				ST_IDLE: if (wr_accept) wr_state <= ST_RESP;
				default: if (axil_req.bready) wr_state <= ST_IDLE;
			endcase
			case (rd_state)
				ST_IDLE: if (rd_accept) rd_state <= ST_RESP;
				default: if (axil_req.rready) rd_state <= ST_IDLE;
			endcase
		end
	end

	// held while the response waits
	always_ff @(posedge clk) begin
		if (wr_accept) begin
			bresp_q <= target_resp(aw_target);
		end
		if (rd_accept) begin
			rresp_q <= target_resp(ar_target);
			rdata_q <= rd_mux;
		end
	end

endmodule

/* verilog/tile_pkg.sv */
`include "tile_cfg.svh"

package tile_pkg;

	// one bit per track on each side
	typedef struct packed {
		logic [`TILE_TRACKS-1:0] north;
		logic [`TILE_TRACKS-1:0] east;
		logic [`TILE_TRACKS-1:0] south;
		logic [`TILE_TRACKS-1:0] west;
	} side_tracks_t;

	typedef enum logic [`CFG_ADDR_W-`TILE_ID_W-1:0] {
		CFG_CLB = 4,
		CFG_CB1 = 5,
		CFG_CB0 = 6,
		CFG_SB  = 7
	} cfg_target_e;

	typedef enum logic [1:0] {
		CLB_AND,
		CLB_OR,
		CLB_XOR,
		CLB_NAND
	} clb_op_e;

	// source of an outgoing track, sides counted clockwise from the output side
	typedef enum logic [1:0] {
		SB_PE,
		SB_NEXT,
		SB_OPP,
		SB_PREV
	} sb_sel_e;

	localparam logic [1:0] AXI_OKAY   = 2'b00;
	localparam logic [1:0] AXI_SLVERR = 2'b10;

	typedef struct packed {
		logic                   sb_en;
		logic                   cb0_en;
		logic                   cb1_en;
		logic                   clb_en;
		logic [`CFG_DATA_W-1:0] data;
	} cfg_write_t;

	typedef struct packed {
		logic [`SB_SEL_W-1:0] sb;
		logic [`CB_SEL_W-1:0] cb0;
		logic [`CB_SEL_W-1:0] cb1;
		clb_op_e              clb;
	} cfg_readback_t;

	typedef struct packed {
		logic                   awvalid;
		logic [`CFG_ADDR_W-1:0] awaddr;
		logic                   wvalid;
		logic [`CFG_DATA_W-1:0] wdata;
		logic                   bready;
		logic                   arvalid;
		logic [`CFG_ADDR_W-1:0] araddr;
		logic                   rready;
	} axil_req_t;

	typedef struct packed {
		logic                   awready;
		logic                   wready;
		logic                   bvalid;
		logic [1:0]             bresp;
		logic                   arready;
		logic                   rvalid;
		logic [`CFG_DATA_W-1:0] rdata;
		logic [1:0]             rresp;
	} axil_rsp_t;

endpackage

/* include/tile_cfg.svh */
`ifndef TILE_CFG_SVH
`define TILE_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~
// tile geometry
// ~~~~~~~~~~~~~~~~~~~~

`define TILE_SIDES 4   // north, east, south, west
`define TILE_TRACKS 4  // per side and direction

// ~~~~~~~~~~~~~~~~~~~~
// configuration bus
// ~~~~~~~~~~~~~~~~~~~~

`define CFG_ADDR_W 32
`define CFG_DATA_W 32

// lower address half carries the tile id, upper half the target
`define TILE_ID_W (`CFG_ADDR_W / 2)

// register widths derived from the geometry
`define CB_SEL_W $clog2(2 * `TILE_TRACKS)           // one of in + out tracks
`define SB_SEL_W (2 * `TILE_SIDES * `TILE_TRACKS)   // 2 bits per outgoing track

`endif
